// ==== hw/gfx_bus_pkg.sv ====
package gfx_bus_pkg;

    // Byte addressed bus, one 32-bit word per transfer
    localparam int BUS_ADDR_W = 12;
    localparam int BUS_DATA_W = 32;

    // Size of the shared frame memory in words
    localparam int MEM_WORDS = 256;

    // Request queue depth in the memory, also the credits the arbiter starts with
    localparam int CREDIT_DEPTH = 2;

    typedef enum logic {
        BUS_READ,
        BUS_WRITE
    } bus_op_t;

    // Owner tag of an outstanding request
    typedef enum logic {
        MST_CLEAR,
        MST_SCAN
    } master_id_t;

endpackage

// ==== hw/gfx_frame_pkg.sv ====
package gfx_frame_pkg;

    // Fixed frame geometry, 8-bit pixels packed four to a word
    localparam int FB_W = 16;
    localparam int FB_H = 8;
    localparam int PIX_PER_WORD = 4;

    // Colour buffer
    localparam int COLOR_WORDS = 32;
    localparam int COLOR_BASE = 0;

    // Depth buffer, one word per pixel
    localparam int DEPTH_BASE = 128;
    localparam int DEPTH_WORDS = 128;
    localparam logic [31:0] DEPTH_CLEAR = 32'hFFFF_FFFF;

    // Blanking, in pixel cycles and in lines
    localparam int H_BLANK = 8;
    localparam int V_BLANK = 2;

    typedef enum logic [1:0] {
        IDLE,
        CLR_COLOR,
        CLR_DEPTH
    } clear_state_t;

    typedef enum logic [1:0] {
        SCAN_WAIT,
        SCAN_ACTIVE,
        SCAN_HBLANK,
        SCAN_VBLANK
    } scan_state_t;

endpackage

// ==== hw/buffer_clear.sv ====
`timescale 1ns/1ps

module buffer_clear (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               start_i,
    input  logic [7:0]                         color_i,
    output logic                               busy_o,
    output logic                               req_o,
    output gfx_bus_pkg::bus_op_t               op_o,
    output logic [gfx_bus_pkg::BUS_ADDR_W-1:0] addr_o,
    output logic [gfx_bus_pkg::BUS_DATA_W-1:0] wdata_o,
    input  logic                               ack_i
);
    import gfx_bus_pkg::*;
    import gfx_frame_pkg::*;

    localparam int WORD_BYTES = BUS_DATA_W / 8;
    localparam logic [BUS_ADDR_W-1:0] WORD_STEP = BUS_ADDR_W'(WORD_BYTES);
    localparam logic [BUS_ADDR_W-1:0] COLOR_FIRST = BUS_ADDR_W'(COLOR_BASE);
    localparam logic [BUS_ADDR_W-1:0] COLOR_LAST =
        BUS_ADDR_W'(COLOR_BASE + WORD_BYTES * (COLOR_WORDS - 1));
    localparam logic [BUS_ADDR_W-1:0] DEPTH_FIRST = BUS_ADDR_W'(DEPTH_BASE);
    localparam logic [BUS_ADDR_W-1:0] DEPTH_LAST =
        BUS_ADDR_W'(DEPTH_BASE + WORD_BYTES * (DEPTH_WORDS - 1));

    clear_state_t          state_q;
    logic [BUS_ADDR_W-1:0] addr_q;
    logic [7:0]            color_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= IDLE;
            addr_q  <= COLOR_FIRST;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CLR_COLOR;
                        addr_q  <= COLOR_FIRST;
                    end
                end
                CLR_COLOR: begin
                    if (ack_i && addr_q == COLOR_LAST) begin
                        state_q <= CLR_DEPTH;
                        addr_q  <= DEPTH_FIRST;
                    end else if (ack_i) begin
                        addr_q <= addr_q + WORD_STEP;
                    end
                end
                CLR_DEPTH: begin
                    if (ack_i && addr_q == DEPTH_LAST) begin
                        state_q <= IDLE;
                    end else if (ack_i) begin
                        addr_q <= addr_q + WORD_STEP;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Colour is taken once per clear
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            color_q <= color_i;
        end
    end

    assign busy_o  = (state_q != IDLE);
    assign req_o   = (state_q != IDLE);
    assign op_o    = BUS_WRITE;
    assign addr_o  = addr_q;
    assign wdata_o = (state_q == CLR_DEPTH) ? DEPTH_CLEAR : {PIX_PER_WORD{color_q}};

endmodule

// ==== hw/scanout_reader.sv ====
`timescale 1ns/1ps

module scanout_reader (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               enable_i,
    output logic                               req_o,
    output gfx_bus_pkg::bus_op_t               op_o,
    output logic [gfx_bus_pkg::BUS_ADDR_W-1:0] addr_o,
    input  logic                               ack_i,
    input  logic                               rvalid_i,
    input  logic [gfx_bus_pkg::BUS_DATA_W-1:0] rdata_i,
    output logic [7:0]                         pixel_o,
    output logic                               pixel_valid_o,
    output logic                               hsync_o,
    output logic                               vsync_o,
    output logic                               underrun_o
);
    import gfx_bus_pkg::*;
    import gfx_frame_pkg::*;

    localparam int VBLANK_CYC = V_BLANK * (FB_W + H_BLANK);
    localparam int CNT_W = $clog2(VBLANK_CYC);
    localparam int LINE_W = $clog2(FB_H);
    localparam int FETCH_W = $clog2(COLOR_WORDS);
    localparam int BYTE_W = $clog2(PIX_PER_WORD);
    localparam logic [CNT_W-1:0] VBLANK_LAST = CNT_W'(VBLANK_CYC - 1);
    localparam logic [CNT_W-1:0] ACTIVE_LAST = CNT_W'(FB_W - 1);
    localparam logic [CNT_W-1:0] HBLANK_LAST = CNT_W'(H_BLANK - 1);
    localparam logic [LINE_W-1:0] LINE_LAST = LINE_W'(FB_H - 1);
    localparam logic [FETCH_W-1:0] FETCH_LAST = FETCH_W'(COLOR_WORDS - 1);

    scan_state_t           state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [LINE_W-1:0]     line_q;
    logic [FETCH_W-1:0]    fetch_q;
    logic                  req_q;
    logic [1:0]            pend_q;
    logic [1:0]            level_q;
    logic                  wr_ptr_q;
    logic                  rd_ptr_q;
    logic [BUS_DATA_W-1:0] buf_q [2];
    logic [BUS_DATA_W-1:0] cur_q;
    logic                  underrun_q;
    logic                  word_start;
    logic                  pop;
    logic                  starve;
    logic                  push;
    logic                  fetch_ok;

    // A new word is due on every fourth pixel of a line
    assign word_start = (state_q == SCAN_ACTIVE) && (cnt_q[BYTE_W-1:0] == '0);
    assign pop        = word_start && (level_q != 2'd0);
    assign starve     = word_start && (level_q == 2'd0);
    assign push       = rvalid_i && (state_q != SCAN_WAIT);
    // Buffered plus in-flight words never exceed the two buffer slots
    assign fetch_ok   = (state_q != SCAN_WAIT) &&
                        (({1'b0, level_q} + {1'b0, pend_q}) < 3'd2);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= SCAN_WAIT;
            cnt_q   <= '0;
            line_q  <= '0;
        end else begin
            case (state_q)
                SCAN_WAIT: begin
                    cnt_q <= '0;
                    // Start only once stray reads from the last frame are gone
                    if (enable_i && pend_q == 2'd0 && !req_q) begin
                        state_q <= SCAN_VBLANK;
                    end
                end
                SCAN_VBLANK: begin
                    if (cnt_q == VBLANK_LAST) begin
                        cnt_q   <= '0;
                        line_q  <= '0;
                        state_q <= enable_i ? SCAN_ACTIVE : SCAN_WAIT;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                SCAN_ACTIVE: begin
                    if (cnt_q == ACTIVE_LAST) begin
                        cnt_q   <= '0;
                        state_q <= SCAN_HBLANK;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                SCAN_HBLANK: begin
                    if (cnt_q == HBLANK_LAST) begin
                        cnt_q   <= '0;
                        line_q  <= line_q + 1'b1;
                        state_q <= (line_q == LINE_LAST) ? SCAN_VBLANK : SCAN_ACTIVE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= SCAN_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_q      <= 1'b0;
            pend_q     <= 2'd0;
            fetch_q    <= '0;
            level_q    <= 2'd0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            if (req_q && ack_i) begin
                req_q <= 1'b0;
            end else if (fetch_ok) begin
                req_q <= 1'b1;
            end
            case ({req_q && ack_i, rvalid_i})
                2'b10:   pend_q <= pend_q + 1'b1;
                2'b01:   pend_q <= pend_q - 1'b1;
                default: pend_q <= pend_q;
            endcase
            if (state_q == SCAN_WAIT) begin
                // Drop the buffer so the next frame fetches from word zero
                fetch_q  <= '0;
                level_q  <= 2'd0;
                wr_ptr_q <= 1'b0;
                rd_ptr_q <= 1'b0;
            end else begin
                if (req_q && ack_i) begin
                    fetch_q <= (fetch_q == FETCH_LAST) ? '0 : fetch_q + 1'b1;
                end
                if (push) begin
                    wr_ptr_q <= ~wr_ptr_q;
                end
                if (pop) begin
                    rd_ptr_q <= ~rd_ptr_q;
                end
                level_q <= level_q + {1'b0, push} - {1'b0, pop};
            end
            if (starve) begin
                underrun_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= rdata_i;
        end
        if (pop) begin
            cur_q <= buf_q[rd_ptr_q] >> 8;
        end else if (starve) begin
            cur_q <= '0;
        end else begin
            cur_q <= cur_q >> 8;
        end
    end

    assign req_o  = req_q;
    assign op_o   = BUS_READ;
    assign addr_o = BUS_ADDR_W'(COLOR_BASE) + BUS_ADDR_W'({fetch_q, 2'b00});

    // Lowest byte goes out first
    assign pixel_o       = word_start ? (pop ? buf_q[rd_ptr_q][7:0] : 8'd0) : cur_q[7:0];
    assign pixel_valid_o = (state_q == SCAN_ACTIVE);
    assign hsync_o       = (state_q == SCAN_HBLANK);
    assign vsync_o       = (state_q == SCAN_VBLANK);
    assign underrun_o    = underrun_q;

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               clr_req_i,
    input  gfx_bus_pkg::bus_op_t               clr_op_i,
    input  logic [gfx_bus_pkg::BUS_ADDR_W-1:0] clr_addr_i,
    input  logic [gfx_bus_pkg::BUS_DATA_W-1:0] clr_wdata_i,
    output logic                               clr_ack_o,
    output logic                               clr_rvalid_o,
    output logic [gfx_bus_pkg::BUS_DATA_W-1:0] clr_rdata_o,
    input  logic                               scan_req_i,
    input  gfx_bus_pkg::bus_op_t               scan_op_i,
    input  logic [gfx_bus_pkg::BUS_ADDR_W-1:0] scan_addr_i,
    input  logic [gfx_bus_pkg::BUS_DATA_W-1:0] scan_wdata_i,
    output logic                               scan_ack_o,
    output logic                               scan_rvalid_o,
    output logic [gfx_bus_pkg::BUS_DATA_W-1:0] scan_rdata_o,
    output logic                               mem_req_o,
    output gfx_bus_pkg::bus_op_t               mem_op_o,
    output logic [gfx_bus_pkg::BUS_ADDR_W-1:0] mem_addr_o,
    output logic [gfx_bus_pkg::BUS_DATA_W-1:0] mem_wdata_o,
    input  logic                               credit_i,
    input  logic                               rsp_valid_i,
    input  logic [gfx_bus_pkg::BUS_DATA_W-1:0] rsp_rdata_i
);
    import gfx_bus_pkg::*;

    localparam int CRED_W = $clog2(CREDIT_DEPTH + 1);
    localparam int PTR_W = (CREDIT_DEPTH > 1) ? $clog2(CREDIT_DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(CREDIT_DEPTH - 1);

    logic [CRED_W-1:0] credits_q;
    master_id_t        last_q;
    master_id_t        own_id_q [CREDIT_DEPTH];
    bus_op_t           own_op_q [CREDIT_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic              can_issue;
    logic              grant_clr;
    logic              grant_scan;
    logic              rsp_read;

    // Round robin, the master not served last wins a tie
    assign can_issue  = (credits_q != '0);
    assign grant_clr  = can_issue && clr_req_i && (!scan_req_i || last_q == MST_SCAN);
    assign grant_scan = can_issue && scan_req_i && (!clr_req_i || last_q == MST_CLEAR);

    assign clr_ack_o   = grant_clr;
    assign scan_ack_o  = grant_scan;
    assign mem_req_o   = grant_clr || grant_scan;
    assign mem_op_o    = grant_scan ? scan_op_i : clr_op_i;
    assign mem_addr_o  = grant_scan ? scan_addr_i : clr_addr_i;
    assign mem_wdata_o = grant_scan ? scan_wdata_i : clr_wdata_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credits_q <= CRED_W'(CREDIT_DEPTH);
            last_q    <= MST_SCAN;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
        end else begin
            case ({mem_req_o, credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
            if (mem_req_o) begin
                last_q   <= grant_scan ? MST_SCAN : MST_CLEAR;
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rsp_valid_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // Owner FIFO, responses return in request order
    always_ff @(posedge clk) begin
        if (mem_req_o) begin
            own_id_q[wr_ptr_q] <= grant_scan ? MST_SCAN : MST_CLEAR;
            own_op_q[wr_ptr_q] <= mem_op_o;
        end
    end

    // Write responses only free the FIFO entry
    assign rsp_read      = rsp_valid_i && (own_op_q[rd_ptr_q] == BUS_READ);
    assign clr_rvalid_o  = rsp_read && (own_id_q[rd_ptr_q] == MST_CLEAR);
    assign scan_rvalid_o = rsp_read && (own_id_q[rd_ptr_q] == MST_SCAN);
    assign clr_rdata_o   = rsp_rdata_i;
    assign scan_rdata_o  = rsp_rdata_i;

endmodule

// ==== hw/frame_mem.sv ====
`timescale 1ns/1ps

module frame_mem (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               req_i,
    input  gfx_bus_pkg::bus_op_t               op_i,
    input  logic [gfx_bus_pkg::BUS_ADDR_W-1:0] addr_i,
    input  logic [gfx_bus_pkg::BUS_DATA_W-1:0] wdata_i,
    output logic                               credit_o,
    output logic                               rsp_valid_o,
    output logic [gfx_bus_pkg::BUS_DATA_W-1:0] rsp_rdata_o
);
    import gfx_bus_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(CREDIT_DEPTH + 1);
    localparam int PTR_W = (CREDIT_DEPTH > 1) ? $clog2(CREDIT_DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(CREDIT_DEPTH - 1);

    bus_op_t               q_op   [CREDIT_DEPTH];
    logic [IDX_W-1:0]      q_idx  [CREDIT_DEPTH];
    logic [BUS_DATA_W-1:0] q_data [CREDIT_DEPTH];
    logic [BUS_DATA_W-1:0] mem    [MEM_WORDS];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  served_q;
    logic [BUS_DATA_W-1:0] rdata_q;
    logic                  pop;

    // Head of the queue is served every cycle it is occupied
    assign pop = (count_q != '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            served_q <= 1'b0;
        end else begin
            if (req_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + {{(CNT_W-1){1'b0}}, req_i} - {{(CNT_W-1){1'b0}}, pop};
            served_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            q_op[wr_ptr_q]   <= op_i;
            q_idx[wr_ptr_q]  <= addr_i[IDX_W+1:2];
            q_data[wr_ptr_q] <= wdata_i;
        end
        if (pop && q_op[rd_ptr_q] == BUS_WRITE) begin
            mem[q_idx[rd_ptr_q]] <= q_data[rd_ptr_q];
        end
        if (pop) begin
            rdata_q <= mem[q_idx[rd_ptr_q]];
        end
    end

    // Each served request returns its credit along with the response
    assign credit_o    = served_q;
    assign rsp_valid_o = served_q;
    assign rsp_rdata_o = rdata_q;

endmodule

// ==== hw/gfx_frame_top.sv ====
`timescale 1ns/1ps

module gfx_frame_top (
    input  logic       clk,
    input  logic       nrst,
    input  logic       clear_start_i,
    input  logic [7:0] clear_color_i,
    input  logic       scan_enable_i,
    output logic       clear_busy_o,
    output logic [7:0] pixel_o,
    output logic       pixel_valid_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       underrun_o
);
    import gfx_bus_pkg::*;

    logic                  clr_req;
    bus_op_t               clr_op;
    logic [BUS_ADDR_W-1:0] clr_addr;
    logic [BUS_DATA_W-1:0] clr_wdata;
    logic                  clr_ack;
    logic                  scan_req;
    bus_op_t               scan_op;
    logic [BUS_ADDR_W-1:0] scan_addr;
    logic                  scan_ack;
    logic                  scan_rvalid;
    logic [BUS_DATA_W-1:0] scan_rdata;
    logic                  mem_req;
    bus_op_t               mem_op;
    logic [BUS_ADDR_W-1:0] mem_addr;
    logic [BUS_DATA_W-1:0] mem_wdata;
    logic                  credit;
    logic                  rsp_valid;
    logic [BUS_DATA_W-1:0] rsp_rdata;

    buffer_clear i_buffer_clear (
        .clk     (clk),
        .nrst    (nrst),
        .start_i (clear_start_i),
        .color_i (clear_color_i),
        .busy_o  (clear_busy_o),
        .req_o   (clr_req),
        .op_o    (clr_op),
        .addr_o  (clr_addr),
        .wdata_o (clr_wdata),
        .ack_i   (clr_ack)
    );

    scanout_reader i_scanout_reader (
        .clk           (clk),
        .nrst          (nrst),
        .enable_i      (scan_enable_i),
        .req_o         (scan_req),
        .op_o          (scan_op),
        .addr_o        (scan_addr),
        .ack_i         (scan_ack),
        .rvalid_i      (scan_rvalid),
        .rdata_i       (scan_rdata),
        .pixel_o       (pixel_o),
        .pixel_valid_o (pixel_valid_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .underrun_o    (underrun_o)
    );

    // The clear engine only writes, so its read return is left open
    bus_arbiter i_bus_arbiter (
        .clk           (clk),
        .nrst          (nrst),
        .clr_req_i     (clr_req),
        .clr_op_i      (clr_op),
        .clr_addr_i    (clr_addr),
        .clr_wdata_i   (clr_wdata),
        .clr_ack_o     (clr_ack),
        .clr_rvalid_o  (),
        .clr_rdata_o   (),
        .scan_req_i    (scan_req),
        .scan_op_i     (scan_op),
        .scan_addr_i   (scan_addr),
        .scan_wdata_i  ('0),
        .scan_ack_o    (scan_ack),
        .scan_rvalid_o (scan_rvalid),
        .scan_rdata_o  (scan_rdata),
        .mem_req_o     (mem_req),
        .mem_op_o      (mem_op),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .credit_i      (credit),
        .rsp_valid_i   (rsp_valid),
        .rsp_rdata_i   (rsp_rdata)
    );

    frame_mem i_frame_mem (
        .clk         (clk),
        .nrst        (nrst),
        .req_i       (mem_req),
        .op_i        (mem_op),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .credit_o    (credit),
        .rsp_valid_o (rsp_valid),
        .rsp_rdata_o (rsp_rdata)
    );

endmodule

// ==== bench/gfx_frame_checker.sv ====
`timescale 1ns/1ps

module gfx_frame_checker (
    input logic                                             clk,
    input logic                                             nrst,
    input logic                                             mem_req_i,
    input logic                                             rsp_valid_i,
    input logic [$clog2(gfx_bus_pkg::CREDIT_DEPTH + 1)-1:0] credits_i,
    input logic                                             clr_ack_i,
    input logic                                             scan_ack_i
);
    import gfx_bus_pkg::*;

    // Requests sent to the memory still waiting for their response
    logic [3:0] outstanding_q;

    // Assertion failures seen so far
    int fail_count = 0;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            outstanding_q <= 4'd0;
        end else begin
            case ({mem_req_i, rsp_valid_i})
                2'b10:   outstanding_q <= outstanding_q + 4'd1;
                2'b01:   outstanding_q <= outstanding_q - 4'd1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    a_outstanding_bound: assert property (@(posedge clk) disable iff (!nrst)
        outstanding_q <= 4'(CREDIT_DEPTH))
        else begin
            fail_count++;
            $error("more requests in flight than the memory queue holds");
        end

    // A free credit means fewer requests in flight than queue slots
    a_req_needs_credit: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_i |-> (outstanding_q < 4'(CREDIT_DEPTH)))
        else begin
            fail_count++;
            $error("memory request issued with no credit left");
        end

    a_single_ack: assert property (@(posedge clk) disable iff (!nrst)
        !(clr_ack_i && scan_ack_i))
        else begin
            fail_count++;
            $error("both masters acknowledged in one cycle");
        end

    // Credits held plus requests in flight always add up to the queue depth
    a_credit_balance: assert property (@(posedge clk) disable iff (!nrst)
        (4'(credits_i) + outstanding_q) == 4'(CREDIT_DEPTH))
        else begin
            fail_count++;
            $error("credit count out of step with requests in flight");
        end

endmodule

bind bus_arbiter gfx_frame_checker i_gfx_frame_checker (
    .clk         (clk),
    .nrst        (nrst),
    .mem_req_i   (mem_req_o),
    .rsp_valid_i (rsp_valid_i),
    .credits_i   (credits_q),
    .clr_ack_i   (clr_ack_o),
    .scan_ack_i  (scan_ack_o)
);

// ==== bench/gfx_frame_tb.sv ====
`timescale 1ns/1ps

module gfx_frame_tb;
    import gfx_frame_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYC = 8;
    localparam int LINE_CYC = FB_W + H_BLANK;
    localparam int VBLANK_CYC = V_BLANK * LINE_CYC;
    localparam int FRAME_CYC = (V_BLANK + FB_H) * LINE_CYC;
    // Room for the clear, the skipped frame and the idle gap of one row
    localparam int ROW_MARGIN = 4 * FRAME_CYC;
    localparam int NUM_ROWS = 5;

    typedef struct packed {
        logic [7:0] color;
        logic       enable;
        int         frames;
    } row_t;

    // Clear colour, scanout enable, frames to check
    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'h3C, 1'b1, 2},
        '{8'hA5, 1'b1, 2},
        '{8'h00, 1'b0, 1},
        '{8'h5A, 1'b1, 1},
        '{8'hC3, 1'b1, 1}
    };

    logic       clk;
    logic       nrst;
    logic       clear_start;
    logic [7:0] clear_color;
    logic       scan_enable;
    logic       clear_busy;
    logic [7:0] pixel;
    logic       pixel_valid;
    logic       hsync;
    logic       vsync;
    logic       underrun;

    gfx_frame_top i_gfx_frame_top (
        .clk           (clk),
        .nrst          (nrst),
        .clear_start_i (clear_start),
        .clear_color_i (clear_color),
        .scan_enable_i (scan_enable),
        .clear_busy_o  (clear_busy),
        .pixel_o       (pixel),
        .pixel_valid_o (pixel_valid),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .underrun_o    (underrun)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pixel(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // Pulse start and follow busy until the clear engine is done
    task automatic run_clear(input logic [7:0] color);
        int busy_cycles;
        busy_cycles = 0;
        @(posedge clk);
        clear_start <= 1'b1;
        clear_color <= color;
        @(posedge clk);
        clear_start <= 1'b0;
        @(negedge clk);
        check_flag(clear_busy, 1'b1, "clear busy one cycle after start");
        while (clear_busy) begin
            busy_cycles++;
            @(negedge clk);
        end
        // Every colour and depth word needs an ack of its own
        check_flag(busy_cycles >= COLOR_WORDS + DEPTH_WORDS, 1'b1,
                   "clear busy long enough for every write");
    endtask

    // Leave the frame in progress and stop at the start of the next vertical blank
    task automatic skip_to_next_frame();
        while (vsync) begin
            @(negedge clk);
        end
        while (!vsync) begin
            @(negedge clk);
        end
    endtask

    // Entered on the first vsync cycle, returns on the first vsync cycle of the next frame
    task automatic check_frame(input logic [7:0] color);
        int vcount;
        int pcount;
        int hcount;
        vcount = 0;
        while (vsync) begin
            check_flag(pixel_valid, 1'b0, "pixel valid during vertical blank");
            vcount++;
            @(negedge clk);
        end
        check_count(vcount, VBLANK_CYC, "vertical blank length");
        for (int line = 0; line < FB_H; line++) begin
            pcount = 0;
            while (pixel_valid) begin
                check_pixel(pixel, color, "pixel colour");
                pcount++;
                @(negedge clk);
            end
            check_count(pcount, FB_W, "valid pixels in line");
            hcount = 0;
            while (hsync) begin
                hcount++;
                @(negedge clk);
            end
            check_count(hcount, H_BLANK, "horizontal blank length");
        end
    endtask

    // Wait for the reader to stop, then watch the output stay quiet
    task automatic check_idle(input int frames);
        while (pixel_valid || hsync || vsync) begin
            @(negedge clk);
        end
        repeat (frames * FRAME_CYC) begin
            @(negedge clk);
            check_flag(pixel_valid, 1'b0, "pixel valid with scanout disabled");
        end
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYC;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += 2 * ROWS[r].frames * FRAME_CYC + ROW_MARGIN;
        end
        return total;
    endfunction

    initial begin
        repeat (watchdog_cycles()) begin
            @(posedge clk);
        end
        $display("ERROR: the run timed out after %0d clock cycles", watchdog_cycles());
        stop_with_failure();
    end

    // Underrun is sticky, so any starved pixel shows up here
    initial begin
        @(posedge nrst);
        forever begin
            @(negedge clk);
            check_flag(underrun, 1'b0, "underrun flag");
            // Arbiter assertions counted by the bound checker
            check_count(i_gfx_frame_top.i_bus_arbiter.i_gfx_frame_checker.fail_count, 0,
                        "arbiter assertion failures");
        end
    end

    initial begin
        int gap;
        nrst        <= 1'b0;
        clear_start <= 1'b0;
        clear_color <= 8'h00;
        scan_enable <= 1'b0;
        void'($urandom(98));
        repeat (RESET_CYC) begin
            @(posedge clk);
        end
        nrst <= 1'b1;
        @(negedge clk);
        check_flag(clear_busy, 1'b0, "clear busy after reset");
        check_flag(pixel_valid, 1'b0, "pixel valid after reset");
        check_flag(hsync, 1'b0, "hsync after reset");
        check_flag(vsync, 1'b0, "vsync after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            gap = int'($urandom % 16);
            repeat (gap) begin
                @(posedge clk);
            end
            @(posedge clk);
            scan_enable <= ROWS[r].enable;
            run_clear(ROWS[r].color);
            if (ROWS[r].enable) begin
                skip_to_next_frame();
                repeat (ROWS[r].frames) begin
                    check_frame(ROWS[r].color);
                end
            end else begin
                check_idle(ROWS[r].frames);
            end
        end
        check_flag(underrun, 1'b0, "underrun flag at end of run");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== src.f ====
hw/gfx_bus_pkg.sv
hw/gfx_frame_pkg.sv
hw/buffer_clear.sv
hw/scanout_reader.sv
hw/bus_arbiter.sv
hw/frame_mem.sv
hw/gfx_frame_top.sv
bench/gfx_frame_checker.sv
bench/gfx_frame_tb.sv

// ==== Makefile ====
# Verilator build and run for the frame memory testbench

VERILATOR ?= verilator
TOP       ?= gfx_frame_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A failing run ends in $$fatal, so the exit status carries the result
run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
